//--- logic/sonic_pkg.sv
// ==========================================================================
// Shared types for the transmit data ring
// Wishbone classic only. No bursts, no err/rty and no byte selects
// A data write is always a full 128-bit block
// ==========================================================================

package sonic_pkg;

   // Host request, held stable by the master until ack
   typedef struct packed {
      logic         cyc;
      logic         stb;
      logic         we;
      // Single register select bit, see wb_reg_e
      logic         adr;
      logic [127:0] dat;
   } wb_req_t;

   // Slave response
   typedef struct packed {
      logic         ack;
      // Free-slot count sits in the low bits on level reads
      logic [127:0] dat;
   } wb_rsp_t;

   // Line-side beat, ready comes back as its own wire
   typedef struct packed {
      logic        valid;
      logic [63:0] data;
   } tx_beat_t;

   // Register map on adr
   typedef enum logic {
      REG_DATA  = 1'b0,
      REG_LEVEL = 1'b1
   } wb_reg_e;

   // Writer FSM
   typedef enum logic {
      W_IDLE = 1'b0,
      W_ACK  = 1'b1
   } wr_state_e;

endpackage

//--- logic/sonic_dpram_32.sv
// ==========================================================================
// 32-bit simple dual-port bank, one clock
// Read-during-write to the same address returns the old word
// q holds its value while rden is low
// ==========================================================================

`timescale 1ns/1ps

module sonic_dpram_32 #(
   parameter int WR_AW = 6
) (
   input  logic             clk,
   input  logic             wren,
   input  logic [WR_AW-1:0] wraddress,
   input  logic [31:0]      data,
   input  logic             rden,
   input  logic [WR_AW-1:0] rdaddress,
   output logic [31:0]      q
);

   localparam int DEPTH = 2 ** WR_AW;

   // Storage, no reset
   logic [31:0] mem [DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (wren) begin
         mem[wraddress] <= data;
      end
   end

   // Registered read, one cycle latency
   always_ff @(posedge clk) begin
      if (rden) begin
         q <= mem[rdaddress];
      end
   end

endmodule

//--- logic/sonic_data_ring_128_64.sv
// ==========================================================================
// Block store, 128 bits in and 64 bits out
// Each block spreads over four 32-bit banks at one address
// Read address low bit picks the half: 0 gives bits 63:0, 1 gives 127:64
// Output valid one cycle after rden
// ==========================================================================

`timescale 1ns/1ps

module sonic_data_ring_128_64 #(
   parameter int WR_AW = 6
) (
   input  logic           clk,
   input  logic           wren,
   input  logic [WR_AW-1:0] wraddress,
   input  logic [127:0]   data,
   input  logic           rden,
   input  logic [WR_AW:0] rdaddress,
   output logic [63:0]    q
);

   // Per-bank read data
   logic [31:0] lane_q [4];

   // Bank row address, half-select bit dropped
   logic [WR_AW-1:0] rd_row;

   // Half select, lined up with the bank output
   logic sel_hi;

   assign rd_row = rdaddress[WR_AW:1];

   // Four lanes, lane 0 is the least significant word
   for (genvar i = 0; i < 4; i++) begin : g_lane
      sonic_dpram_32 #(
         .WR_AW(WR_AW)
      ) u_bank (
         .clk(clk),
         .wren(wren),
         .wraddress(wraddress),
         .data(data[32*i +: 32]),
         .rden(rden),
         .rdaddress(rd_row),
         .q(lane_q[i])
      );
   end

   // Capture the half bit with the read itself
   // so q stays consistent while rden is low
   always_ff @(posedge clk) begin
      if (rden) begin
         sel_hi <= rdaddress[0];
      end
   end

   // Lanes 0/1 for the low half, 2/3 for the high half
   always_comb begin
      if (sel_hi) begin
         q = {lane_q[3], lane_q[2]};
      end else begin
         q = {lane_q[1], lane_q[0]};
      end
   end

endmodule

//--- logic/sonic_ring_writer.sv
// ==========================================================================
// Wishbone classic slave, write side of the ring
// adr 0 takes a 128-bit block, adr 1 reads the free-slot count
// A data write to a full ring is stalled, ack comes once a slot frees
// Ack is a single cycle, the master must drop stb on the next edge
// ==========================================================================

`timescale 1ns/1ps

module sonic_ring_writer
   import sonic_pkg::*;
#(
   parameter int WR_AW = 6
) (
   input  logic             clk,
   input  logic             rst,
   input  wb_req_t          wb_req,
   output wb_rsp_t          wb_rsp,
   input  logic [WR_AW+1:0] rd_ptr,
   output logic [WR_AW:0]   wr_ptr,
   output logic             wren,
   output logic [WR_AW-1:0] wraddress,
   output logic [127:0]     wdata
);

   localparam int DEPTH = 2 ** WR_AW;
   localparam logic [WR_AW:0] DEPTH_CNT = (WR_AW+1)'(DEPTH);

   wr_state_e      state;
   wb_reg_e        reg_sel;
   logic           req;
   logic           data_wr;
   logic           accept;
   logic           full;
   logic           level_rd;
   logic [WR_AW:0] occ;
   logic [WR_AW:0] free;

   // New cycle only looked at in W_IDLE
   assign req     = wb_req.cyc && wb_req.stb && (state == W_IDLE);
   assign reg_sel = wb_reg_e'(wb_req.adr);

   // Blocks held, rd_ptr counts halves so drop its low bit
   // wrap bit makes occ == DEPTH distinct from empty
   assign occ  = wr_ptr - rd_ptr[WR_AW+1:1];
   assign full = (occ == DEPTH_CNT);
   assign free = DEPTH_CNT - occ;

   // Decode the access
   always_comb begin
      data_wr = 1'b0;
      unique case (reg_sel)
         REG_DATA:  data_wr = wb_req.we;
         REG_LEVEL: data_wr = 1'b0;
      endcase
   end

   // Everything except a data write into a full ring gets acked
   assign accept = req && !(data_wr && full);

   // Block goes into the banks on the accept edge
   assign wren      = req && data_wr && !full;
   assign wraddress = wr_ptr[WR_AW-1:0];
   assign wdata     = wb_req.dat;

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= W_IDLE;
         wr_ptr   <= '0;
         level_rd <= 1'b0;
      end else begin
         case (state)
            W_IDLE: begin
               if (accept) begin
                  state    <= W_ACK;
                  // Remember whether the ack carries the level
                  level_rd <= !wb_req.we && (reg_sel == REG_LEVEL);
               end
            end
            W_ACK: begin
               state <= W_IDLE;
            end
            default: begin
               state <= W_IDLE;
            end
         endcase
         // Advance only on a stored block
         if (wren) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   // Level sampled in the ack cycle itself
   // Writes and data reads return zero
   always_comb begin
      wb_rsp.ack = (state == W_ACK);
      wb_rsp.dat = (wb_rsp.ack && level_rd) ? 128'(free) : '0;
   end

endmodule

//--- logic/sonic_ring_reader.sv
// ==========================================================================
// Read side of the ring, drives the 64-bit line stream
// Low half of a block leaves first, then the high half
// A two-entry queue hides the one-cycle memory latency
// tx.data is stable while tx.valid is high and tx_ready is low
// ==========================================================================

`timescale 1ns/1ps

module sonic_ring_reader
   import sonic_pkg::*;
#(
   parameter int WR_AW = 6
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [WR_AW:0]   wr_ptr,
   output logic [WR_AW+1:0] rd_ptr,
   output logic             rden,
   output logic [WR_AW:0]   rdaddress,
   input  logic [63:0]      q,
   output tx_beat_t         tx,
   input  logic             tx_ready
);

   // Queue storage, payload only
   logic [63:0] buf_data [2];

   logic       hd;
   logic       tl;
   logic [1:0] cnt;
   // Read issued last cycle, word is on q now
   logic       rd_vld;
   logic [2:0] held;
   logic       pop;
   logic       empty;
   logic       room;

   // Nothing left when upper bits meet wr_ptr on a block boundary
   assign empty = (rd_ptr[WR_AW+1:1] == wr_ptr) && !rd_ptr[0];

   // Stream handshake
   assign pop = (cnt != 2'd0) && tx_ready;

   // Held entries plus the word in flight
   assign held = {1'b0, cnt} + {2'b0, rd_vld};

   // A pop this cycle frees a slot for the next arrival
   // which keeps the stream at one beat per cycle
   assign room = held < (3'd2 + {2'b0, pop});

   assign rden      = !empty && room;
   assign rdaddress = rd_ptr[WR_AW:0];

   // Pointer and queue control
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_ptr <= '0;
         rd_vld <= 1'b0;
         hd     <= 1'b0;
         tl     <= 1'b0;
         cnt    <= 2'd0;
      end else begin
         rd_vld <= rden;
         if (rden) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (rd_vld) begin
            tl <= ~tl;
         end
         if (pop) begin
            hd <= ~hd;
         end
         // Net occupancy change
         case ({rd_vld, pop})
            2'b10:   cnt <= cnt + 2'd1;
            2'b01:   cnt <= cnt - 2'd1;
            default: cnt <= cnt;
         endcase
      end
   end

   // Capture the returning word at the tail
   always_ff @(posedge clk) begin
      if (rd_vld) begin
         buf_data[tl] <= q;
      end
   end

   // Head of queue is the beat on offer
   always_comb begin
      tx.valid = (cnt != 2'd0);
      tx.data  = buf_data[hd];
   end

endmodule

//--- logic/sonic_tx_ring.sv
// ==========================================================================
// Transmit data ring top, single clock and synchronous reset
// Host writes 128-bit blocks over Wishbone classic
// Line side pulls 64-bit beats, low half first
// WR_AW sets the depth, 2**WR_AW blocks, valid from 2 to 10
// ==========================================================================

`timescale 1ns/1ps

module sonic_tx_ring
   import sonic_pkg::*;
#(
   parameter int WR_AW = 6
) (
   input  logic     clk,
   input  logic     rst,
   input  wb_req_t  wb_req,
   output wb_rsp_t  wb_rsp,
   output tx_beat_t tx,
   input  logic     tx_ready
);

   // Writer to ring
   logic             wren;
   logic [WR_AW-1:0] wraddress;
   logic [127:0]     wdata;

   // Reader to ring
   logic             rden;
   logic [WR_AW:0]   rdaddress;
   logic [63:0]      q;

   // Pointer exchange between the two sides
   logic [WR_AW:0]   wr_ptr;
   logic [WR_AW+1:0] rd_ptr;

   // Host side, owns the full test
   sonic_ring_writer #(
      .WR_AW(WR_AW)
   ) u_writer (
      .clk(clk),
      .rst(rst),
      .wb_req(wb_req),
      .wb_rsp(wb_rsp),
      .rd_ptr(rd_ptr),
      .wr_ptr(wr_ptr),
      .wren(wren),
      .wraddress(wraddress),
      .wdata(wdata)
   );

   // Block storage
   sonic_data_ring_128_64 #(
      .WR_AW(WR_AW)
   ) u_ring (
      .clk(clk),
      .wren(wren),
      .wraddress(wraddress),
      .data(wdata),
      .rden(rden),
      .rdaddress(rdaddress),
      .q(q)
   );

   // Line side, owns the empty test
   sonic_ring_reader #(
      .WR_AW(WR_AW)
   ) u_reader (
      .clk(clk),
      .rst(rst),
      .wr_ptr(wr_ptr),
      .rd_ptr(rd_ptr),
      .rden(rden),
      .rdaddress(rdaddress),
      .q(q),
      .tx(tx),
      .tx_ready(tx_ready)
   );

endmodule

//--- tb/tb_sonic_tx_ring.sv
// ==========================================================================
// Random-stimulus testbench for the transmit data ring, depth 16 blocks
// Model is a queue of 64-bit beats, low half of each block pushed first
// Inputs driven on the rising edge, outputs sampled on the falling edge
// Level check allows one extra free block for reader prefetch
// ==========================================================================

`timescale 1ns/1ps

module tb_sonic_tx_ring
   import sonic_pkg::*;
();

   localparam int WR_AW = 4;
   localparam int DEPTH = 2 ** WR_AW;
   localparam int ACK_LIMIT = 300;

   logic     clk;
   logic     rst;
   wb_req_t  wb_req;
   wb_rsp_t  wb_rsp;
   tx_beat_t tx;
   logic     tx_ready;

   // Expected beats in stream order
   logic [63:0] model_q[$];
   logic        pop_pending;
   logic        prev_hold;
   logic [63:0] prev_data;

   integer seed;
   integer ready_seed;
   // 0 ready high, 1 ready low, 2 random with about a third low
   int     ready_mode;
   int     errors;
   int     tests_run;
   int     tests_failed;
   int     beats_seen;

   sonic_tx_ring #(
      .WR_AW(WR_AW)
   ) UUT (
      .clk(clk),
      .rst(rst),
      .wb_req(wb_req),
      .wb_rsp(wb_rsp),
      .tx(tx),
      .tx_ready(tx_ready)
   );

   always #4 clk = ~clk;

   // Line-side ready pattern
   always @(posedge clk) begin
      case (ready_mode)
         0:       tx_ready <= 1'b1;
         1:       tx_ready <= 1'b0;
         default: tx_ready <= (($random(ready_seed) % 3) != 0);
      endcase
   end

   // Head of the model compared with the beat on offer
   task automatic check_beat(input tx_beat_t beat);
      if (model_q.size() == 0) begin
         errors++;
         $display("ERROR %0t: beat %h leaves with nothing written", $time, beat.data);
      end else if (beat.data !== model_q[0]) begin
         errors++;
         $display("ERROR %0t: beat %h, expected %h", $time, beat.data, model_q[0]);
      end
   endtask

   // Free slots against blocks that still owe a beat
   task automatic check_level(input wb_rsp_t rsp);
      int outstanding;
      int expected;
      int got;
      outstanding = (model_q.size() + 1) / 2;
      expected    = DEPTH - outstanding;
      got         = int'(rsp.dat[31:0]);
      // Up to two beats fetched ahead can release one block early
      if (got != expected && !(outstanding > 0 && got == expected + 1)) begin
         errors++;
         $display("ERROR %0t: level %0d, expected %0d", $time, got, expected);
      end
   endtask

   // Stream monitor
   always @(negedge clk) begin
      if (rst) begin
         prev_hold = 1'b0;
      end else begin
         // Stalled beat must not move
         if (prev_hold && (!tx.valid || tx.data !== prev_data)) begin
            errors++;
            $display("ERROR %0t: stalled beat changed from %h to %h", $time, prev_data,
                     tx.data);
         end
         if (tx.valid && tx_ready) begin
            check_beat(tx);
            beats_seen++;
            pop_pending = 1'b1;
         end
         prev_hold = tx.valid && !tx_ready;
         prev_data = tx.data;
      end
   end

   // Model pop lands on the edge that takes the beat
   always @(posedge clk) begin
      if (pop_pending && model_q.size() != 0) begin
         void'(model_q.pop_front());
      end
      pop_pending = 1'b0;
   end

   task automatic drive_req(input logic we, input logic adr, input logic [127:0] dat);
      wb_req_t r;
      r.cyc = 1'b1;
      r.stb = 1'b1;
      r.we  = we;
      r.adr = adr;
      r.dat = dat;
      @(posedge clk);
      wb_req <= r;
   endtask

   task automatic release_req();
      @(posedge clk);
      wb_req <= '0;
   endtask

   // Ack seen on a falling edge, bounded by limit cycles
   task automatic wait_ack(input int limit, output logic got);
      int n;
      got = 1'b0;
      n   = 0;
      while (!got && n < limit) begin
         @(negedge clk);
         if (wb_rsp.ack) begin
            got = 1'b1;
         end else begin
            n++;
         end
      end
   endtask

   task automatic push_block(input logic [127:0] dat);
      model_q.push_back(dat[63:0]);
      model_q.push_back(dat[127:64]);
   endtask

   task automatic write_block(input logic [127:0] dat);
      logic got;
      drive_req(1'b1, REG_DATA, dat);
      wait_ack(ACK_LIMIT, got);
      if (got) begin
         push_block(dat);
      end else begin
         errors++;
         $display("ERROR %0t: data write got no ack in %0d cycles", $time, ACK_LIMIT);
      end
      release_req();
   endtask

   task automatic read_level(output int count);
      logic got;
      count = -1;
      drive_req(1'b0, REG_LEVEL, '0);
      wait_ack(ACK_LIMIT, got);
      if (got) begin
         check_level(wb_rsp);
         count = int'(wb_rsp.dat[31:0]);
      end else begin
         errors++;
         $display("ERROR %0t: level read got no ack in %0d cycles", $time, ACK_LIMIT);
      end
      release_req();
   endtask

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while (model_q.size() != 0 && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (model_q.size() != 0) begin
         errors++;
         $display("ERROR %0t: stream stopped with %0d beats missing", $time, model_q.size());
      end
   endtask

   function automatic logic [127:0] rand_block();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   task automatic host_gap();
      logic [31:0] r;
      r = $random(seed);
      repeat (r[1:0]) @(posedge clk);
   endtask

   task automatic finish_test(input string name, input int err_start);
      tests_run++;
      if (errors == err_start) begin
         $display("test %-14s passed", name);
      end else begin
         tests_failed++;
         $display("test %-14s failed with %0d errors", name, errors - err_start);
      end
   endtask

   initial begin
      int          err_start;
      int          beats_start;
      int          level;
      int          n;
      logic        got;
      logic [31:0] r;
      logic [127:0] blk;
      clk          = 1'b0;
      rst          = 1'b1;
      wb_req       = '0;
      tx_ready     = 1'b0;
      seed         = 32'hda1dc6f1;
      ready_seed   = 32'hda1dc6f1;
      ready_mode   = 0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      beats_seen   = 0;
      pop_pending  = 1'b0;
      prev_hold    = 1'b0;
      prev_data    = '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      // Idle stream and full level
      err_start = errors;
      @(negedge clk);
      if (tx.valid !== 1'b0) begin
         errors++;
         $display("ERROR %0t: tx.valid is %b after reset", $time, tx.valid);
      end
      read_level(level);
      finish_test("reset", err_start);

      // Single block gives two beats, low half first
      err_start   = errors;
      beats_start = beats_seen;
      write_block(rand_block());
      wait_drain(ACK_LIMIT);
      repeat (20) @(negedge clk);
      if (beats_seen - beats_start != 2) begin
         errors++;
         $display("ERROR %0t: %0d beats for one block", $time, beats_seen - beats_start);
      end
      finish_test("one_block", err_start);

      // Random traffic with ready low a third of the time
      err_start  = errors;
      ready_mode = 2;
      for (int i = 0; i < 200; i++) begin
         host_gap();
         write_block(rand_block());
      end
      wait_drain(4 * ACK_LIMIT);
      finish_test("random", err_start);

      // Fill with the line side stalled
      err_start  = errors;
      ready_mode = 1;
      repeat (2) @(posedge clk);
      level = DEPTH;
      n     = 0;
      while (level != 0 && n < DEPTH + 4) begin
         write_block(rand_block());
         read_level(level);
         n++;
      end
      if (level != 0) begin
         errors++;
         $display("ERROR %0t: level stuck at %0d with the stream stalled", $time, level);
      end
      blk = rand_block();
      drive_req(1'b1, REG_DATA, blk);
      wait_ack(20, got);
      if (got) begin
         errors++;
         $display("ERROR %0t: write into a full ring was acked", $time);
         push_block(blk);
      end else begin
         // Draining frees a slot and lets the held write in
         ready_mode = 0;
         wait_ack(ACK_LIMIT, got);
         if (got) begin
            push_block(blk);
         end else begin
            errors++;
            $display("ERROR %0t: stalled write never completed", $time);
         end
      end
      release_req();
      wait_drain(4 * ACK_LIMIT);
      finish_test("full", err_start);

      // Level reads mixed into random traffic
      err_start  = errors;
      ready_mode = 2;
      for (int i = 0; i < 80; i++) begin
         host_gap();
         r = $random(seed);
         if (r % 3 == 0) begin
            read_level(level);
         end else begin
            write_block(rand_block());
         end
      end
      wait_drain(4 * ACK_LIMIT);
      read_level(level);
      finish_test("mixed_level", err_start);

      $display("tests %0d, failed %0d, errors %0d, beats %0d", tests_run, tests_failed,
               errors, beats_seen);
      if (errors == 0 && tests_failed == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- tb.f
logic/sonic_pkg.sv
logic/sonic_dpram_32.sv
logic/sonic_data_ring_128_64.sv
logic/sonic_ring_writer.sv
logic/sonic_ring_reader.sv
logic/sonic_tx_ring.sv
tb/tb_sonic_tx_ring.sv

//--- Makefile
# Verilator build and run for the transmit ring testbench

TOP := tb_sonic_tx_ring
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

# Pass only when the log holds the pass line
run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "simulation failed"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
